//--- hw/audio_pkg.sv
`default_nettype none

package audio_pkg;

  // ====================
  // Flash bus
  // ====================

  // Word address into the song memory
  typedef logic [22:0] flash_addr_t;

  // One 32-bit bus word with its two samples in bytes 1 and 3
  typedef logic [31:0] flash_word_t;

  // ====================
  // Audio path
  // ====================

  // Unsigned 8-bit audio sample
  typedef logic [7:0] sample_t;

  // Reader FSM states
  typedef enum logic [2:0] {
    idle,
    request,
    wait_data,
    emit_first,
    emit_second
  } reader_state_t;

endpackage

`default_nettype wire

//--- hw/control_pkg.sv
`default_nettype none

package control_pkg;

  // ====================
  // Key commands
  // ====================

  typedef logic [7:0] ascii_t;

  // Upper case ASCII letters
  localparam ascii_t key_play     = 8'h45;
  localparam ascii_t key_pause    = 8'h44;
  localparam ascii_t key_forward  = 8'h46;
  localparam ascii_t key_backward = 8'h42;
  localparam ascii_t key_replay   = 8'h52;

  // ====================
  // Speed and display
  // ====================

  // Sample period in clock cycles
  typedef logic [15:0] divider_t;

  typedef logic [3:0] hex_digit_t;

  // Active low segments with a in bit 0 and g in bit 6
  typedef logic [6:0] segments_t;

endpackage

`default_nettype wire

//--- hw/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
  input  logic                CLK_50M,
  input  logic                speed_reset_event,
  input  logic                cmd_valid,
  input  control_pkg::ascii_t cmd_code,
  input  logic                replay_done,
  output logic                cmd_ready,
  output logic                playing,
  output logic                forward,
  output logic                replay_req
);

  import control_pkg::*;

  logic cmd_accept;

  // Stall new keys until the reader has restarted
  assign cmd_ready  = ~replay_req;
  assign cmd_accept = cmd_valid & cmd_ready;

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      playing    <= 1'b0;
      forward    <= 1'b1;
      replay_req <= 1'b0;
    end
    else
    begin
      if (replay_done)
        replay_req <= 1'b0;
      if (cmd_accept)
      begin
        case (cmd_code)
          key_play:     playing    <= 1'b1;
          key_pause:    playing    <= 1'b0;
          key_forward:  forward    <= 1'b1;
          key_backward: forward    <= 1'b0;
          key_replay:   replay_req <= 1'b1;
          // Anything else is swallowed
          default: ;
        endcase
      end
    end
  end

  // Reader may only confirm a restart that was asked for
  a_done_needs_req: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    replay_done |-> replay_req)
    else $error("replay_done without a pending replay request");

endmodule

`default_nettype wire

//--- hw/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control #(
  parameter control_pkg::divider_t DEFAULT_DIVIDER = 16'd614,
  parameter control_pkg::divider_t MIN_DIVIDER     = 16'd4,
  parameter int                    REPEAT_CYCLES   = 5_000_000
) (
  input  logic                  CLK_50M,
  input  logic                  speed_reset_event,
  input  logic                  speed_up,
  input  logic                  speed_down,
  output control_pkg::divider_t divider,
  output logic                  sample_tick
);

  import control_pkg::*;

  localparam int REPEAT_W = $clog2(REPEAT_CYCLES + 1);

  logic [REPEAT_W-1:0] repeat_count;
  logic                key_held;
  logic                step_event;
  divider_t            period;
  divider_t            tick_count;

  // ====================
  // Key repeat
  // ====================

  // Both keys together cancel out
  assign key_held   = speed_up ^ speed_down;
  assign step_event = key_held && (repeat_count == '0);

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      repeat_count <= '0;
    else if (!key_held)
      repeat_count <= '0;
    else if (repeat_count == REPEAT_W'(REPEAT_CYCLES - 1))
      repeat_count <= '0;
    else
      repeat_count <= repeat_count + 1'b1;
  end

  // ====================
  // Divider register
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      divider <= DEFAULT_DIVIDER;
    else if (step_event)
    begin
      // Faster playback means a shorter period
      if (speed_up)
      begin
        if (divider > MIN_DIVIDER)
          divider <= divider - 1'b1;
      end
      else if (divider != '1)
        divider <= divider + 1'b1;
    end
  end

  // ====================
  // Sample tick
  // ====================

  // Period is latched at each tick so a change waits for the next one
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      tick_count  <= '0;
      period      <= DEFAULT_DIVIDER;
      sample_tick <= 1'b0;
    end
    else if (tick_count == period - 1'b1)
    begin
      tick_count  <= '0;
      period      <= divider;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_count  <= tick_count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_divider_floor: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    divider >= MIN_DIVIDER)
    else $error("divider dropped below its floor");

endmodule

`default_nettype wire

//--- hw/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader #(
  parameter audio_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  input  logic                   sample_tick,
  input  logic                   playing,
  input  logic                   forward,
  input  logic                   replay_req,
  input  logic                   flash_waitrequest,
  input  audio_pkg::flash_word_t flash_readdata,
  input  logic                   flash_readdatavalid,
  output logic                   flash_read,
  output audio_pkg::flash_addr_t flash_address,
  output audio_pkg::sample_t     sample_out,
  output logic                   sample_valid,
  output logic                   replay_done
);

  import audio_pkg::*;

  reader_state_t state;
  flash_addr_t   address;
  flash_addr_t   next_address;
  flash_addr_t   restart_address;
  sample_t       second_sample;
  logic          can_restart;
  logic          replay_now;
  logic          capture_word;
  logic          emit_high;

  assign flash_read    = (state == request);
  assign flash_address = address;

  // ====================
  // Address stepping
  // ====================

  always_comb
  begin
    if (forward)
      next_address = (address == LAST_ADDR) ? '0 : address + 1'b1;
    else
      next_address = (address == '0) ? LAST_ADDR : address - 1'b1;
  end

  assign restart_address = forward ? '0 : LAST_ADDR;

  // Replay only once no read is in flight
  assign can_restart = (state == idle) || (state == emit_first) || (state == emit_second)
                       || ((state == wait_data) && flash_readdatavalid);

  // Skip the cycle where the last restart is being confirmed
  assign replay_now = replay_req && !replay_done && can_restart;

  assign capture_word = (state == wait_data) && flash_readdatavalid && !replay_now;
  assign emit_high    = ((state == emit_first) || (state == emit_second))
                        && sample_tick && playing && !replay_now;

  // ====================
  // Read FSM
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      state        <= idle;
      address      <= '0;
      sample_valid <= 1'b0;
      replay_done  <= 1'b0;
    end
    else
    begin
      sample_valid <= capture_word | emit_high;
      replay_done  <= replay_now;
      if (replay_now)
      begin
        // Pending second sample is dropped
        address <= restart_address;
        state   <= idle;
      end
      else
      begin
        case (state)
          idle:
            if (sample_tick && playing)
              state <= request;
          request:
            if (!flash_waitrequest)
              state <= wait_data;
          wait_data:
            if (flash_readdatavalid)
              state <= emit_first;
          emit_first, emit_second:
            if (emit_high)
            begin
              address <= next_address;
              state   <= idle;
            end
            else
              state <= emit_second;
          default:
            state <= idle;
        endcase
      end
    end
  end

  // Low byte goes out at once, high byte waits for the next tick
  always_ff @(posedge CLK_50M)
  begin
    if (capture_word)
    begin
      sample_out    <= flash_readdata[15:8];
      second_sample <= flash_readdata[31:24];
    end
    else if (emit_high)
      sample_out <= second_sample;
  end

  a_req_stable: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("flash request changed while stalled");

  a_data_expected: assert property (@(posedge CLK_50M) disable iff (speed_reset_event)
    flash_readdatavalid |-> state == wait_data)
    else $error("flash data returned with no read outstanding");

endmodule

`default_nettype wire

//--- hw/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display (
  input  control_pkg::divider_t  divider,
  output control_pkg::segments_t hex0,
  output control_pkg::segments_t hex1,
  output control_pkg::segments_t hex2,
  output control_pkg::segments_t hex3,
  output control_pkg::segments_t hex4,
  output control_pkg::segments_t hex5
);

  import control_pkg::*;

  localparam segments_t seg_blank = 7'h7F;

  // Segment pattern for one hex digit, lit segments are 0
  function automatic segments_t encode_digit(input hex_digit_t digit);
    case (digit)
      4'h0:    encode_digit = 7'h40;
      4'h1:    encode_digit = 7'h79;
      4'h2:    encode_digit = 7'h24;
      4'h3:    encode_digit = 7'h30;
      4'h4:    encode_digit = 7'h19;
      4'h5:    encode_digit = 7'h12;
      4'h6:    encode_digit = 7'h02;
      4'h7:    encode_digit = 7'h78;
      4'h8:    encode_digit = 7'h00;
      4'h9:    encode_digit = 7'h10;
      4'hA:    encode_digit = 7'h08;
      4'hB:    encode_digit = 7'h03;
      4'hC:    encode_digit = 7'h46;
      4'hD:    encode_digit = 7'h21;
      4'hE:    encode_digit = 7'h06;
      default: encode_digit = 7'h0E;
    endcase
  endfunction

  assign hex0 = encode_digit(divider[3:0]);
  assign hex1 = encode_digit(divider[7:4]);
  assign hex2 = encode_digit(divider[11:8]);
  assign hex3 = encode_digit(divider[15:12]);

  // Upper two digits have nothing to show
  assign hex4 = seg_blank;
  assign hex5 = seg_blank;

endmodule

`default_nettype wire

//--- hw/simple_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module simple_ipod #(
  parameter control_pkg::divider_t  DEFAULT_DIVIDER = 16'd614,
  parameter control_pkg::divider_t  MIN_DIVIDER     = 16'd4,
  parameter int                     REPEAT_CYCLES   = 5_000_000,
  parameter audio_pkg::flash_addr_t LAST_ADDR       = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   speed_reset_event,
  // Key commands
  input  logic                   cmd_valid,
  input  control_pkg::ascii_t    cmd_code,
  output logic                   cmd_ready,
  input  logic                   speed_up,
  input  logic                   speed_down,
  // Flash bus
  output logic                   flash_read,
  output audio_pkg::flash_addr_t flash_address,
  input  logic                   flash_waitrequest,
  input  audio_pkg::flash_word_t flash_readdata,
  input  logic                   flash_readdatavalid,
  // Audio and display
  output audio_pkg::sample_t     sample_out,
  output logic                   sample_valid,
  output control_pkg::segments_t hex0,
  output control_pkg::segments_t hex1,
  output control_pkg::segments_t hex2,
  output control_pkg::segments_t hex3,
  output control_pkg::segments_t hex4,
  output control_pkg::segments_t hex5
);

  import control_pkg::*;

  logic     playing;
  logic     forward;
  logic     replay_req;
  logic     replay_done;
  logic     sample_tick;
  divider_t divider;

  command_decoder i_command_decoder (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .cmd_valid         (cmd_valid),
    .cmd_code          (cmd_code),
    .replay_done       (replay_done),
    .cmd_ready         (cmd_ready),
    .playing           (playing),
    .forward           (forward),
    .replay_req        (replay_req)
  );

  speed_control #(
    .DEFAULT_DIVIDER (DEFAULT_DIVIDER),
    .MIN_DIVIDER     (MIN_DIVIDER),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) i_speed_control (
    .CLK_50M           (CLK_50M),
    .speed_reset_event (speed_reset_event),
    .speed_up          (speed_up),
    .speed_down        (speed_down),
    .divider           (divider),
    .sample_tick       (sample_tick)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) i_flash_reader (
    .CLK_50M             (CLK_50M),
    .speed_reset_event   (speed_reset_event),
    .sample_tick         (sample_tick),
    .playing             (playing),
    .forward             (forward),
    .replay_req          (replay_req),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .sample_out          (sample_out),
    .sample_valid        (sample_valid),
    .replay_done         (replay_done)
  );

  hex_display i_hex_display (
    .divider (divider),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

`default_nettype wire

//--- testbench/tb_simple_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_simple_ipod;

  import audio_pkg::*;
  import control_pkg::*;

  localparam divider_t    default_divider = 16'd40;
  localparam divider_t    min_divider     = 16'd4;
  localparam int          repeat_cycles   = 50;
  localparam flash_addr_t last_addr       = 23'd15;
  localparam int          wait_limit      = 1000;
  localparam int          timeout_margin  = 20000;

  typedef enum {bus_idle, bus_stall, bus_return} bus_mode_t;

  logic        CLK_50M             = 1'b0;
  logic        speed_reset_event   = 1'b1;
  logic        cmd_valid           = 1'b0;
  ascii_t      cmd_code            = 8'h00;
  logic        speed_up            = 1'b0;
  logic        speed_down          = 1'b0;
  logic        flash_waitrequest   = 1'b0;
  flash_word_t flash_readdata      = '0;
  logic        flash_readdatavalid = 1'b0;
  logic        cmd_ready;
  logic        flash_read;
  flash_addr_t flash_address;
  sample_t     sample_out;
  logic        sample_valid;
  segments_t   hex0, hex1, hex2, hex3, hex4, hex5;

  sample_t     sample_q[$];
  int          cycle_count = 0;
  int          cycle_limit = 0;
  bit          dir_forward = 1'b1;
  bus_mode_t   bus_mode    = bus_idle;
  int          stall_left;
  int          return_left;
  flash_addr_t held_addr;

  simple_ipod #(
    .DEFAULT_DIVIDER (default_divider),
    .MIN_DIVIDER     (min_divider),
    .REPEAT_CYCLES   (repeat_cycles),
    .LAST_ADDR       (last_addr)
  ) i_simple_ipod (
    .CLK_50M             (CLK_50M),
    .speed_reset_event   (speed_reset_event),
    .cmd_valid           (cmd_valid),
    .cmd_code            (cmd_code),
    .cmd_ready           (cmd_ready),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_out          (sample_out),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ====================
  // Reporting
  // ====================

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_equal(input string test_name, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("Error %s: expected %0h, actual %0h", test_name, expected, actual);
      fail_run();
    end
  endtask

  // ====================
  // Flash memory model
  // ====================

  // Byte 1 holds a + 0x10 and byte 3 holds a + 0x80
  function automatic flash_word_t word_at(input flash_addr_t addr);
    sample_t low;
    sample_t high;
    low  = sample_t'(addr) + 8'h10;
    high = sample_t'(addr) + 8'h80;
    return {high, 8'h00, low, 8'h00};
  endfunction

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    flash_readdata      = '0;
    if (speed_reset_event)
    begin
      bus_mode          = bus_idle;
      flash_waitrequest = 1'b0;
    end
    else
    begin
      if ((bus_mode == bus_idle) && flash_read)
      begin
        stall_left = int'($urandom % 4);
        bus_mode   = bus_stall;
      end
      if (bus_mode == bus_stall)
      begin
        if (stall_left == 0)
        begin
          // Request taken at the next rising edge
          flash_waitrequest = 1'b0;
          held_addr         = flash_address;
          return_left       = 1 + int'($urandom % 3);
          bus_mode          = bus_return;
        end
        else
        begin
          flash_waitrequest = 1'b1;
          stall_left--;
        end
      end
      else if (bus_mode == bus_return)
      begin
        return_left--;
        if (return_left == 0)
        begin
          flash_readdata      = word_at(held_addr);
          flash_readdatavalid = 1'b1;
          bus_mode            = bus_idle;
        end
      end
    end
  end

  // Sample capture and run limit
  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (sample_valid)
      sample_q.push_back(sample_out);
    if ((cycle_limit > 0) && (cycle_count > cycle_limit))
    begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  // ====================
  // Expected values
  // ====================

  // Active low patterns in bit order g f e d c b a
  function automatic segments_t segments_for(input hex_digit_t digit);
    case (digit)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  function automatic sample_t expected_sample(input int addr, input bit high);
    return high ? sample_t'(addr + 'h80) : sample_t'(addr + 'h10);
  endfunction

  // ====================
  // Test actions
  // ====================

  task automatic check_display(input string test_name, input int expected);
    expect_equal(test_name, int'(segments_for(hex_digit_t'(expected))), int'(hex0));
    expect_equal(test_name, int'(segments_for(hex_digit_t'(expected >> 4))), int'(hex1));
    expect_equal(test_name, int'(segments_for(hex_digit_t'(expected >> 8))), int'(hex2));
    expect_equal(test_name, int'(segments_for(hex_digit_t'(expected >> 12))), int'(hex3));
    // Top two digits dark
    expect_equal(test_name, 'h7F, int'(hex4));
    expect_equal(test_name, 'h7F, int'(hex5));
  endtask

  task automatic send_key(input string test_name, input ascii_t code);
    int waited;
    @(negedge CLK_50M);
    cmd_valid = 1'b1;
    cmd_code  = code;
    waited    = 0;
    while (!cmd_ready)
    begin
      @(negedge CLK_50M);
      waited++;
      if (waited > wait_limit)
      begin
        $display("Key in %s was never accepted", test_name);
        fail_run();
      end
    end
    @(negedge CLK_50M);
    cmd_valid = 1'b0;
    if (code == key_forward)
      dir_forward = 1'b1;
    else if (code == key_backward)
      dir_forward = 1'b0;
    if (code == key_replay)
    begin
      // Input stalls until the reader has restarted
      expect_equal(test_name, 0, int'(cmd_ready));
      waited = 0;
      while (!cmd_ready)
      begin
        @(negedge CLK_50M);
        waited++;
        if (waited > wait_limit)
        begin
          $display("cmd_ready stayed low after the replay in %s", test_name);
          fail_run();
        end
      end
    end
  endtask

  task automatic hold_key(input string test_name, input bit faster, input int periods,
                          input int expected);
    @(negedge CLK_50M);
    speed_up   = faster;
    speed_down = !faster;
    repeat (periods * repeat_cycles) @(negedge CLK_50M);
    speed_up   = 1'b0;
    speed_down = 1'b0;
    @(negedge CLK_50M);
    check_display(test_name, expected);
  endtask

  // Exact count for a wait window and within one for a rate window
  task automatic count_samples(input string test_name, input int cycles, input int expected,
                               input bit exact);
    int got;
    @(negedge CLK_50M);
    sample_q.delete();
    repeat (cycles) @(negedge CLK_50M);
    got = sample_q.size();
    sample_q.delete();
    if (exact || (got < expected - 1) || (got > expected + 1))
      expect_equal(test_name, expected, got);
  endtask

  task automatic collect_samples(input string test_name, input int count, input int first);
    int      addr;
    int      waited;
    int      i;
    bit      high;
    sample_t got;
    high = (first >= 'h80);
    addr = high ? first - 'h80 : first - 'h10;
    for (i = 0; i < count; i++)
    begin
      waited = 0;
      while (sample_q.size() == 0)
      begin
        @(negedge CLK_50M);
        waited++;
        if (waited > wait_limit)
        begin
          $display("No sample arrived during %s", test_name);
          fail_run();
        end
      end
      got = sample_q.pop_front();
      expect_equal(test_name, int'(expected_sample(addr, high)), int'(got));
      // Address moves after the high byte and wraps at both ends
      if (high)
      begin
        if (dir_forward)
          addr = (addr == int'(last_addr)) ? 0 : addr + 1;
        else
          addr = (addr == 0) ? int'(last_addr) : addr - 1;
      end
      high = !high;
    end
  endtask

  task automatic run_test(input string test_name, input string action, input int count,
                          input int expected);
    if (action == "wait")
      count_samples(test_name, count, expected, 1'b1);
    else if (action == "rate")
      count_samples(test_name, count, expected, 1'b0);
    else if (action == "collect")
      collect_samples(test_name, count, expected);
    else if (action == "display")
      check_display(test_name, expected);
    else if (action == "hold_up")
      hold_key(test_name, 1'b1, count, expected);
    else if (action == "hold_down")
      hold_key(test_name, 1'b0, count, expected);
    else if (action.len() == 1)
      send_key(test_name, ascii_t'(action[0]));
    else
    begin
      $display("Test %s has an unknown action %s", test_name, action);
      fail_run();
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    int    fd;
    int    total;
    int    idx;
    int    count;
    int    expected;
    string line;
    string name;
    string action;
    string names[$];
    string actions[$];
    int    counts[$];
    int    expects[$];
    void'($urandom(32'h167c));
    fd = $fopen("testbench/simple_ipod_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open testbench/simple_ipod_tests.txt");
      fail_run();
    end
    total = 0;
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() > 1) && (line.substr(0, 0) != "#"))
      begin
        if ($sscanf(line, "%s %s %d %h", name, action, count, expected) == 4)
        begin
          names.push_back(name);
          actions.push_back(action);
          counts.push_back(count);
          expects.push_back(expected);
          total += count;
        end
      end
    end
    $fclose(fd);
    if (names.size() == 0)
    begin
      $display("The test data file holds no tests");
      fail_run();
    end
    cycle_limit = total * int'(default_divider) + timeout_margin;

    repeat (5) @(negedge CLK_50M);
    speed_reset_event = 1'b0;

    for (idx = 0; idx < names.size(); idx++)
      run_test(names[idx], actions[idx], counts[idx], expects[idx]);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- simple_ipod.f
hw/audio_pkg.sv
hw/control_pkg.sv
hw/command_decoder.sv
hw/speed_control.sv
hw/flash_reader.sv
hw/hex_display.sv
hw/simple_ipod.sv
testbench/tb_simple_ipod.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_simple_ipod
RTL_TOP    ?= simple_ipod
FILELIST   ?= simple_ipod.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/simple_ipod_tests.txt
# Columns: test name, action, count, expected value in hex
# Keys E D F B R Z; hold_up/hold_down count repeat periods; wait/rate count cycles
reset_quiet        wait       200   0
reset_display      display    0     0028
play_key           E          0     0
forward_wrap       collect    34    10
back_key           B          0     0
backward_wrap      collect    8     11
pause_key          D          0     0
paused_quiet       wait       300   0
forward_key        F          0     0
replay_forward     R          0     0
resume_key         E          0     0
replay_start       collect    3     10
back_again_key     B          0     0
replay_backward    R          0     0
backward_restart   collect    4     1f
pause_again        D          0     0
faster_three       hold_up    3     0025
faster_to_floor    hold_up    40    0004
slower_to_default  hold_down  36    0028
slower_fifty       hold_down  10    0032
play_again         E          0     0
rate_at_fifty      rate       1000  14
faster_to_forty    hold_up    10    0028
rate_at_forty      rate       800   14
junk_key           Z          0     0
still_playing      rate       400   a
